// ==== design/axiLiteMaster.sv ====
module axiLiteMaster (
  input  logic                            clk,
  input  logic                            rst_n,
  input  dcachePkg::cacheStateE           state_i,
  input  dcachePkg::reqInfoT              info_i,
  input  logic [dcachePkg::AddrWidth-1:0] victimAddr_i,
  input  dcachePkg::lineT                 victimLine_i,
  output dcachePkg::axiReqT               axiReq_o,
  input  dcachePkg::axiRspT               axiRsp_i,
  output logic                            wbDone_o,
  output logic                            refillDone_o,
  output dcachePkg::lineT                 refillLine_o
);
  import dcachePkg::*;

  logic [$clog2(LineWords)-1:0] beatCnt;
  logic beatBusy;
  logic awValid, wValid, bReady, arValid, rReady;
  logic wbDone, refillDone;
  logic bFire, rFire;
  logic [AddrWidth-1:0] beatOffset;
  logic [AddrWidth-1:0] refillBase;
  lineT refillBuf;

  assign bFire = bReady && axiRsp_i.bvalid;
  assign rFire = rReady && axiRsp_i.rvalid;
  assign beatOffset = AddrWidth'({beatCnt, 3'b000});
  assign refillBase = {info_i.tag, info_i.index, {OffsetWidth{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
      beatBusy <= 1'b0;
      {awValid, wValid, bReady, arValid, rReady} <= '0;
      wbDone <= 1'b0;
      refillDone <= 1'b0;
    end else begin
      wbDone <= 1'b0;
      refillDone <= 1'b0;
      // address and data channels drop independently on their handshake
      if (awValid && axiRsp_i.awready) begin
        awValid <= 1'b0;
      end
      if (wValid && axiRsp_i.wready) begin
        wValid <= 1'b0;
      end
      if (arValid && axiRsp_i.arready) begin
        arValid <= 1'b0;
      end
      if (state_i == WriteBack) begin
        if (!beatBusy && !wbDone) begin
          {awValid, wValid, bReady, beatBusy} <= '1;
        end else if (bFire) begin
          bReady <= 1'b0;
          beatBusy <= 1'b0;
          beatCnt <= beatCnt + 1'b1;
          wbDone <= &beatCnt;
        end
      end else if (state_i == Refill) begin
        if (!beatBusy && !refillDone) begin
          {arValid, rReady, beatBusy} <= '1;
        end else if (rFire) begin
          rReady <= 1'b0;
          beatBusy <= 1'b0;
          beatCnt <= beatCnt + 1'b1;
          refillDone <= &beatCnt;
        end
      end
    end
  end

  // refill words land in beat order
  always_ff @(posedge clk) begin
    if (state_i == Refill && rFire) begin
      refillBuf.words[beatCnt] <= axiRsp_i.rdata;
    end
  end

  always_comb begin
    axiReq_o.awvalid = awValid;
    axiReq_o.awaddr = victimAddr_i + beatOffset;
    axiReq_o.wvalid = wValid;
    axiReq_o.wdata = victimLine_i.words[beatCnt];
    axiReq_o.wstrb = '1;
    axiReq_o.bready = bReady;
    axiReq_o.arvalid = arValid;
    axiReq_o.araddr = refillBase + beatOffset;
    axiReq_o.rready = rReady;
  end

  assign wbDone_o = wbDone;
  assign refillDone_o = refillDone;
  assign refillLine_o = refillBuf;

  assert property (@(posedge clk) disable iff (!rst_n)
    (awValid && !axiRsp_i.awready) |=> (awValid && $stable(axiReq_o.awaddr)));

endmodule

// ==== design/cacheCtrl.sv ====
module cacheCtrl (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            reqValid_i,
  input  dcachePkg::reqInfoT              info_i,
  input  logic                            hit_i,
  input  logic                            victimDirty_i,
  input  logic                            wbDone_i,
  input  logic                            refillDone_i,
  input  logic [dcachePkg::DataWidth-1:0] rdWord_i,
  output dcachePkg::cacheStateE           state_o,
  output logic                            accept_o,
  output logic                            reqReady_o,
  output logic                            respValid_o,
  output dcachePkg::cpuRespT              resp_o
);
  import dcachePkg::*;

  cacheStateE stateQ;
  cacheStateE stateD;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= Idle;
    end else begin
      stateQ <= stateD;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      Idle: begin
        if (accept_o) begin
          stateD = Compare;
        end
      end
      Compare: begin
        if (hit_i) begin
          stateD = accept_o ? Compare : Idle;
        end else begin
          // dirty victim goes out before the new line comes in
          stateD = victimDirty_i ? WriteBack : Refill;
        end
      end
      WriteBack: begin
        if (wbDone_i) begin
          stateD = Refill;
        end
      end
      Refill: begin
        if (refillDone_i) begin
          stateD = Replace;
        end
      end
      Replace: stateD = Compare;
      default: stateD = Idle;
    endcase
  end

  // a hit in Compare frees the pipeline for the next request at once
  assign reqReady_o = (stateQ == Idle) || (stateQ == Compare && hit_i);
  assign accept_o = reqValid_i && reqReady_o;
  assign respValid_o = (stateQ == Compare) && hit_i;
  assign resp_o.rdata = (info_i.op == Load) ? rdWord_i : '0;
  assign state_o = stateQ;

  // the refilled line hits on the compare right after Replace
  assert property (@(posedge clk) disable iff (!rst_n)
    (stateQ == Replace) |=> respValid_o);

  // refill done only arrives while refilling
  assert property (@(posedge clk) disable iff (!rst_n)
    refillDone_i |-> (stateQ == Refill));

endmodule

// ==== design/dataStore.sv ====
module dataStore (
  input  logic                            clk,
  input  dcachePkg::reqInfoT              info_i,
  input  dcachePkg::cacheStateE           state_i,
  input  logic                            hit_i,
  input  logic                            hitWay_i,
  input  logic                            victimWay_i,
  input  dcachePkg::lineT                 refillLine_i,
  output logic [dcachePkg::DataWidth-1:0] rdWord_o,
  output dcachePkg::lineT                 victimLine_o
);
  import dcachePkg::*;

  logic [LineWidth-1:0] lineMem [Ways][Sets];
  lineT hitLine;
  logic storeHit;
  int unsigned wordBase;

  assign storeHit = (state_i == Compare) && hit_i && (info_i.op == Store);
  assign wordBase = info_i.wordSel * DataWidth;

  always_ff @(posedge clk) begin
    if (state_i == Replace) begin
      lineMem[victimWay_i][info_i.index] <= refillLine_i;
    end else if (storeHit) begin
      // only the masked byte lanes of the selected word change
      for (int b = 0; b < StrbWidth; b++) begin
        if (info_i.wstrb[b]) begin
          lineMem[hitWay_i][info_i.index][wordBase + 8 * b +: 8] <= info_i.wdata[8 * b +: 8];
        end
      end
    end
  end

  // combinational reads so a store is visible to the next cycle's load
  assign hitLine = lineMem[hitWay_i][info_i.index];
  assign rdWord_o = hitLine.words[info_i.wordSel];
  assign victimLine_o = lineMem[victimWay_i][info_i.index];

endmodule

// ==== design/dcachePkg.sv ====
package dcachePkg;

  // address and word geometry
  localparam int AddrWidth = 32;
  localparam int DataWidth = 64;
  localparam int StrbWidth = DataWidth / 8;

  // line geometry
  localparam int LineWords = 4;
  localparam int LineWidth = LineWords * DataWidth;
  localparam int OffsetWidth = 5;

  // two ways of 64 sets each
  localparam int Ways = 2;
  localparam int Sets = 64;
  localparam int IndexWidth = 6;
  localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

  typedef enum logic [2:0] {
    Idle,
    Compare,
    WriteBack,
    Refill,
    Replace
  } cacheStateE;

  typedef enum logic {
    Load,
    Store
  } memOpE;

  typedef struct packed {
    memOpE                op;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] wstrb;
  } cpuReqT;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
  } cpuRespT;

  // latched request with store data and mask already in their byte lanes
  typedef struct packed {
    logic [TagWidth-1:0]          tag;
    logic [IndexWidth-1:0]        index;
    logic [$clog2(LineWords)-1:0] wordSel;
    memOpE                        op;
    logic [DataWidth-1:0]         wdata;
    logic [StrbWidth-1:0]         wstrb;
  } reqInfoT;

  typedef struct packed {
    logic [LineWords-1:0][DataWidth-1:0] words;
  } lineT;

  typedef struct packed {
    logic                 awvalid;
    logic [AddrWidth-1:0] awaddr;
    logic                 wvalid;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] wstrb;
    logic                 bready;
    logic                 arvalid;
    logic [AddrWidth-1:0] araddr;
    logic                 rready;
  } axiReqT;

  typedef struct packed {
    logic                 awready;
    logic                 wready;
    logic                 bvalid;
    logic                 arready;
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
  } axiRspT;

endpackage

// ==== design/dcacheTop.sv ====
module dcacheTop (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                reqValid_i,
  input  dcachePkg::cpuReqT   req_i,
  output logic                reqReady_o,
  output logic                respValid_o,
  output dcachePkg::cpuRespT  resp_o,
  output dcachePkg::axiReqT   axiReq_o,
  input  dcachePkg::axiRspT   axiRsp_i
);
  import dcachePkg::*;

  reqInfoT info;
  cacheStateE state;
  logic accept;
  logic hit, hitWay, victimWay, victimDirty;
  logic [AddrWidth-1:0] victimAddr;
  logic [DataWidth-1:0] rdWord;
  logic wbDone, refillDone;
  lineT refillLine, victimLine;

  reqStage reqStage_inst (
    .clk, .rst_n, .reqValid_i, .req_i, .accept_i(accept), .info_o(info)
  );

  tagStore tagStore_inst (
    .clk, .rst_n, .info_i(info), .state_i(state), .hit_o(hit), .hitWay_o(hitWay),
    .victimWay_o(victimWay), .victimDirty_o(victimDirty), .victimAddr_o(victimAddr)
  );

  dataStore dataStore_inst (
    .clk, .info_i(info), .state_i(state), .hit_i(hit), .hitWay_i(hitWay),
    .victimWay_i(victimWay), .refillLine_i(refillLine), .rdWord_o(rdWord),
    .victimLine_o(victimLine)
  );

  cacheCtrl cacheCtrl_inst (
    .clk, .rst_n, .reqValid_i, .info_i(info), .hit_i(hit), .victimDirty_i(victimDirty),
    .wbDone_i(wbDone), .refillDone_i(refillDone), .rdWord_i(rdWord), .state_o(state),
    .accept_o(accept), .reqReady_o, .respValid_o, .resp_o
  );

  axiLiteMaster axiLiteMaster_inst (
    .clk, .rst_n, .state_i(state), .info_i(info), .victimAddr_i(victimAddr),
    .victimLine_i(victimLine), .axiReq_o, .axiRsp_i, .wbDone_o(wbDone),
    .refillDone_o(refillDone), .refillLine_o(refillLine)
  );

endmodule

// ==== design/reqStage.sv ====
module reqStage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               reqValid_i,
  input  dcachePkg::cpuReqT  req_i,
  input  logic               accept_i,
  output dcachePkg::reqInfoT info_o
);
  import dcachePkg::*;

  reqInfoT infoQ;
  logic [2:0] byteOff;
  logic latchEn;

  // byte position of the access inside its 64-bit word
  assign byteOff = req_i.addr[2:0];
  assign latchEn = reqValid_i && accept_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      infoQ <= '0;
    end else if (latchEn) begin
      infoQ.tag <= req_i.addr[AddrWidth-1 -: TagWidth];
      infoQ.index <= req_i.addr[OffsetWidth +: IndexWidth];
      infoQ.wordSel <= req_i.addr[3 +: $clog2(LineWords)];
      infoQ.op <= req_i.op;
      // move store bytes to their lanes once
      infoQ.wdata <= req_i.wdata << {byteOff, 3'b000};
      infoQ.wstrb <= req_i.wstrb << byteOff;
    end
  end

  assign info_o = infoQ;

endmodule

// ==== design/tagStore.sv ====
module tagStore (
  input  logic                            clk,
  input  logic                            rst_n,
  input  dcachePkg::reqInfoT              info_i,
  input  dcachePkg::cacheStateE           state_i,
  output logic                            hit_o,
  output logic                            hitWay_o,
  output logic                            victimWay_o,
  output logic                            victimDirty_o,
  output logic [dcachePkg::AddrWidth-1:0] victimAddr_o
);
  import dcachePkg::*;

  logic [TagWidth-1:0] tagMem [Ways][Sets];
  logic [Ways-1:0][Sets-1:0] validQ;
  logic [Ways-1:0][Sets-1:0] dirtyQ;
  logic [Ways-1:0] wayHit;
  logic victimBit;
  logic missWay;
  logic missEvt;

  always_comb begin
    for (int w = 0; w < Ways; w++) begin
      wayHit[w] = validQ[w][info_i.index] && (tagMem[w][info_i.index] == info_i.tag);
    end
  end

  assign hit_o = |wayHit;
  assign hitWay_o = wayHit[1];
  assign missEvt = (state_i == Compare) && !hit_o;

  // toggle flips on every miss and missWay keeps the choice for the refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimBit <= 1'b0;
      missWay <= 1'b0;
    end else if (missEvt) begin
      victimBit <= ~victimBit;
      missWay <= victimBit;
    end
  end

  assign victimWay_o = (state_i == Compare) ? victimBit : missWay;
  assign victimDirty_o = validQ[victimWay_o][info_i.index] && dirtyQ[victimWay_o][info_i.index];
  assign victimAddr_o = {tagMem[victimWay_o][info_i.index], info_i.index, {OffsetWidth{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
    end else if (state_i == Replace) begin
      validQ[missWay][info_i.index] <= 1'b1;
      dirtyQ[missWay][info_i.index] <= 1'b0;
    end else if (state_i == Compare && hit_o && info_i.op == Store) begin
      dirtyQ[hitWay_o][info_i.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state_i == Replace) begin
      tagMem[missWay][info_i.index] <= info_i.tag;
    end
  end

  // a line is never filled into a set that already holds it
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == Compare) |-> $onehot0(wayHit));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module dcacheTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/VdcacheTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "all tests passed" "$LOG"; then
  exit 0
fi
exit 1

// ==== src.f ====
+incdir+verif
design/dcachePkg.sv
design/reqStage.sv
design/tagStore.sv
design/dataStore.sv
design/cacheCtrl.sv
design/axiLiteMaster.sv
design/dcacheTop.sv
verif/dcacheTb.sv

// ==== verif/dcacheTests.svh ====
`ifndef DCACHE_TESTS_SVH
`define DCACHE_TESTS_SVH

// one step with request fields, expected load data and expected memory traffic
typedef struct packed {
  memOpE          op;
  logic [31:0]    addr;
  logic [63:0]    wdata;
  logic [7:0]     wstrb;
  logic [63:0]    expData;
  logic           expRefill;
  logic           wbValid;
  logic [31:0]    wbBase;
} testStepT;

localparam int NumTests = 14;

testStepT tests [NumTests];

task automatic loadTable();
  logic [63:0] d1;
  logic [63:0] d2;
  logic [63:0] d3;
  logic [63:0] d4;
  d1 = 64'h1122_3344_5566_7788;
  d2 = 64'hCAFE_F00D_0BAD_BEEF;
  d3 = 64'h0123_4567_89AB_CDEF;
  d4 = 64'h0000_0000_0000_BEEF;
  // cold line in set 2 and then hits on it
  tests[0] = '{Load, 32'h40, 64'h0, 8'h00, patternWord(32'h40), 1'b1, 1'b0, 32'h0};
  tests[1] = '{Load, 32'h48, 64'h0, 8'h00, patternWord(32'h48), 1'b0, 1'b0, 32'h0};
  tests[2] = '{Load, 32'h40, 64'h0, 8'h00, patternWord(32'h40), 1'b0, 1'b0, 32'h0};
  // masked store hit and the load that sees it
  tests[3] = '{Store, 32'h50, d1, 8'h0F, 64'h0, 1'b0, 1'b0, 32'h0};
  tests[4] = '{Load, 32'h50, 64'h0, 8'h00,
               mergeStore(patternWord(32'h50), d1, 8'h0F, 3'd0), 1'b0, 1'b0, 32'h0};
  // lines 0x000, 0x800 and 0x1000 in set 0 compete for two ways
  tests[5] = '{Store, 32'h008, d2, 8'hF0, 64'h0, 1'b1, 1'b0, 32'h0};
  tests[6] = '{Load, 32'h008, 64'h0, 8'h00,
               mergeStore(patternWord(32'h008), d2, 8'hF0, 3'd0), 1'b0, 1'b0, 32'h0};
  tests[7] = '{Store, 32'h818, d3, 8'hFF, 64'h0, 1'b1, 1'b0, 32'h0};
  // way 1 holds dirty 0x000
  tests[8] = '{Load, 32'h1000, 64'h0, 8'h00, patternWord(32'h1000), 1'b1, 1'b1, 32'h000};
  // way 0 holds dirty 0x800 and line 0x000 comes back from memory
  tests[9] = '{Load, 32'h008, 64'h0, 8'h00,
               mergeStore(patternWord(32'h008), d2, 8'hF0, 3'd0), 1'b1, 1'b1, 32'h800};
  // way 1 holds clean 0x1000 so there is no write-back
  tests[10] = '{Load, 32'h818, 64'h0, 8'h00,
                mergeStore(patternWord(32'h818), d3, 8'hFF, 3'd0), 1'b1, 1'b0, 32'h0};
  tests[11] = '{Load, 32'h010, 64'h0, 8'h00, patternWord(32'h010), 1'b0, 1'b0, 32'h0};
  // halfword store at byte offset 2
  tests[12] = '{Store, 32'h5A, d4, 8'h03, 64'h0, 1'b0, 1'b0, 32'h0};
  tests[13] = '{Load, 32'h58, 64'h0, 8'h00,
                mergeStore(patternWord(32'h58), d4, 8'h03, 3'd2), 1'b0, 1'b0, 32'h0};
endtask

`endif

// ==== verif/dcacheTb.sv ====
module dcacheTb;
  import dcachePkg::*;

  localparam int MemWords = 1024;

  logic clk;
  logic rst_n;
  logic reqValid;
  cpuReqT req;
  logic reqReady;
  logic respValid;
  cpuRespT resp;
  axiReqT axiReq;
  axiRspT axiRsp;
  logic awReady, wReady, bValid, arReady, rValid;
  logic [DataWidth-1:0] rData;

  logic [DataWidth-1:0] mem [MemWords];
  logic [DataWidth-1:0] shadow [MemWords];
  axiReqT wrLog [$];
  logic [AddrWidth-1:0] arLog [$];
  int errors;
  int checks;
  int cycleCount;

  // initial memory contents derived from the full word address
  function automatic logic [63:0] patternWord(input logic [31:0] addr);
    return {addr ^ 32'h5A3C_96E1, ~addr};
  endfunction

  // store data and mask moved to the byte offset and merged over the old word
  function automatic logic [63:0] mergeStore(input logic [63:0] old, input logic [63:0] data,
                                             input logic [7:0] strb, input logic [2:0] off);
    logic [63:0] lanes;
    logic [7:0] mask;
    logic [63:0] res;
    lanes = data << (8 * off);
    mask = strb << off;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) res[8 * b +: 8] = lanes[8 * b +: 8];
    end
    return res;
  endfunction

  `include "dcacheTests.svh"

  localparam int CycleLimit = NumTests * 60;

  assign axiRsp = '{awready: awReady, wready: wReady, bvalid: bValid,
                    arready: arReady, rvalid: rValid, rdata: rData};

  dcacheTop dcacheTop_inst (
    .clk, .rst_n, .reqValid_i(reqValid), .req_i(req), .reqReady_o(reqReady),
    .respValid_o(respValid), .resp_o(resp), .axiReq_o(axiReq), .axiRsp_i(axiRsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("timeout after %0d cycles, the cache never finished the tests", cycleCount);
      $display("tests failed");
      $finish;
    end
  end

  task automatic checkResp(input cpuRespT got, input cpuRespT exp);
    checks++;
    if (got.rdata !== exp.rdata) begin
      $display("CHECK FAILED resp_o.rdata got %h expected %h", got.rdata, exp.rdata);
      errors++;
    end
  endtask

  task automatic checkAxiWrite(input axiReqT got, input axiReqT exp);
    checks++;
    if (got.awaddr !== exp.awaddr || got.wdata !== exp.wdata || got.wstrb !== exp.wstrb) begin
      $display("CHECK FAILED axiReq_o awaddr %h wdata %h wstrb %h expected %h %h %h",
               got.awaddr, got.wdata, got.wstrb, exp.awaddr, exp.wdata, exp.wstrb);
      errors++;
    end
  endtask

  task automatic checkAddr(input string name, input logic [AddrWidth-1:0] got,
                           input logic [AddrWidth-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkWord(input string name, input logic [DataWidth-1:0] got,
                           input logic [DataWidth-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // write side of the memory takes AW and W together and then answers on B
  initial begin
    int delay;
    axiReqT beat;
    forever begin
      @(negedge clk);
      if (axiReq.awvalid && axiReq.wvalid) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        beat = axiReq;
        @(posedge clk);
        awReady <= 1'b1;
        wReady <= 1'b1;
        @(posedge clk);
        awReady <= 1'b0;
        wReady <= 1'b0;
        mem[beat.awaddr[12:3]] = beat.wdata;
        wrLog.push_back(beat);
        bValid <= 1'b1;
        do @(negedge clk); while (!axiReq.bready);
        @(posedge clk);
        bValid <= 1'b0;
      end
    end
  end

  // read side takes AR and then returns the stored word on R
  initial begin
    int delay;
    logic [AddrWidth-1:0] addr;
    forever begin
      @(negedge clk);
      if (axiReq.arvalid) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        addr = axiReq.araddr;
        @(posedge clk);
        arReady <= 1'b1;
        @(posedge clk);
        arReady <= 1'b0;
        arLog.push_back(addr);
        rValid <= 1'b1;
        rData <= mem[addr[12:3]];
        do @(negedge clk); while (!axiReq.rready);
        @(posedge clk);
        rValid <= 1'b0;
      end
    end
  end

  task automatic runStep(input int t);
    testStepT s;
    cpuRespT got;
    cpuRespT exp;
    axiReqT expWr;
    logic [AddrWidth-1:0] base;
    logic [AddrWidth-1:0] wbAddr;
    logic [9:0] idx;
    int errBefore;
    int waited;
    s = tests[t];
    errBefore = errors;
    arLog.delete();
    wrLog.delete();
    @(posedge clk);
    reqValid <= 1'b1;
    req <= '{op: s.op, addr: s.addr, wdata: s.wdata, wstrb: s.wstrb};
    @(negedge clk);
    if (!reqReady) begin
      $display("step %0d: cache not ready for a new request", t);
      errors++;
    end
    @(posedge clk);
    reqValid <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!respValid);
    got = resp;
    exp.rdata = s.expData;
    checkResp(got, exp);
    if (!s.expRefill && waited != 1) begin
      $display("step %0d: hit answered after %0d cycles instead of one", t, waited);
      errors++;
    end
    base = s.addr & ~32'h1F;
    if (s.expRefill && arLog.size() != 4) begin
      $display("step %0d: expected 4 refill beats, saw %0d", t, arLog.size());
      errors++;
    end else if (!s.expRefill && arLog.size() != 0) begin
      $display("step %0d: a hit caused %0d refill beats", t, arLog.size());
      errors++;
    end else begin
      foreach (arLog[i]) checkAddr("axiReq_o.araddr", arLog[i], base + 8 * i);
    end
    if (wrLog.size() != (s.wbValid ? 4 : 0)) begin
      $display("step %0d: wrong number of write-back beats, saw %0d", t, wrLog.size());
      errors++;
    end else begin
      foreach (wrLog[i]) begin
        wbAddr = s.wbBase + 8 * i;
        idx = wbAddr[12:3];
        expWr = '0;
        expWr.awaddr = wbAddr;
        expWr.wdata = shadow[idx];
        expWr.wstrb = '1;
        checkAxiWrite(wrLog[i], expWr);
        checkWord("memory word", mem[idx], shadow[idx]);
      end
    end
    if (s.op == Store) begin
      idx = s.addr[12:3];
      shadow[idx] = mergeStore(shadow[idx], s.wdata, s.wstrb, s.addr[2:0]);
    end
    $display("step %0d %s addr %h: %s", t, s.op.name(), s.addr,
             (errors == errBefore) ? "ok" : "FAILED");
  endtask

  initial begin
    void'($urandom(32'h112));
    rst_n = 1'b0;
    reqValid = 1'b0;
    req = '0;
    {awReady, wReady, bValid, arReady, rValid} = '0;
    rData = '0;
    errors = 0;
    checks = 0;
    cycleCount = 0;
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = patternWord(32'(i) << 3);
      shadow[i] = mem[i];
    end
    loadTable();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (!reqReady || respValid || axiReq.awvalid || axiReq.wvalid || axiReq.arvalid ||
        axiReq.bready || axiReq.rready) begin
      $display("after reset the cache is not ready or drives a valid or ready");
      errors++;
    end
    for (int t = 0; t < NumTests; t++) runStep(t);
    $display("%0d steps, %0d checks, %0d errors", NumTests, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
